/* src.f */
hw/pwm_pkg.sv
hw/pwm_cmd_if.sv
hw/host_cmd_target.sv
hw/cmd_queue.sv
hw/pwm_channel.sv
hw/h_bridge_decode.sv
hw/pwm_subsystem.sv
bench/pwm_properties.sv
bench/tb_pwm.sv

/* bench/tb_pwm.sv */
/*
 * testbench for pwm_subsystem, host inputs driven on the falling edge
 * pulse tests use small periods so runs can be counted cycle by cycle
 * protocol rules are covered by the bound pwm_properties assertions
 */
`timescale 1ns/1ns
`default_nettype none

module tb_pwm;
    import pwm_pkg::*;

    localparam int clk_period  = 100;
    localparam int test_cycles = 150 + 300 + 1200 + 150 + 100;   // tests 1 to 5, estimated
    localparam int per_list [5] = '{10, 7, 5, 4, 6};
    localparam int on_list  [5] = '{3, 0, 5, 9, 1};   // zero and at least period included

    logic                  clk = 1'b0;
    logic                  reset, cmd_valid, cmd_write, cmd_ready;
    logic                  rsp_ready, rsp_valid, pwm_out, h_bridge_1, h_bridge_2;
    logic [addr_width-1:0] cmd_addr;
    logic [data_width-1:0] cmd_data, rsp_data, held;
    logic [31:0]           rng = 32'd42;          // xorshift state
    logic [data_width-1:0] model [4];             // expected registers, status slot unused
    logic [data_width-1:0] expect_q [6];          // stalled reads in issue order
    int                    errors = 0, passed = 0, failed = 0, err_mark = 0, asrt_mark = 0, n;

    pwm_subsystem DUT (.*);

    always #(clk_period / 2) clk = ~clk;

    initial begin
        #(2 * test_cycles * clk_period);
        $display("watchdog expired, the tests did not finish in time");
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // {pin 2, pin 1}: command, swap, invert, then bridge enable
    function automatic logic [1:0] bridge_pins(input logic p, input logic [31:0] c);
        logic [1:0] pins;
        case (c[3:2])
            2'd1:    pins = {1'b0, p};
            2'd2:    pins = {p, 1'b0};
            2'd3:    pins = 2'b11;
            default: pins = 2'b00;
        endcase
        if (c[4])
            pins = {pins[0], pins[1]};
        return c[1] ? pins ^ c[6:5] : 2'b00;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic send_cmd(input logic wr, input logic [addr_width-1:0] addr,
                            input logic [data_width-1:0] data);
        cmd_valid = 1'b1;
        cmd_write = wr;
        cmd_addr  = addr;
        cmd_data  = data;
        while (!cmd_ready) @(negedge clk);   // ready moves only on the rising edge
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic write_reg(input logic [addr_width-1:0] addr, input logic [data_width-1:0] data);
        send_cmd(1'b1, addr, data);
        model[addr] = data;
        if (addr == reg_period || addr == reg_on_time)
            model[reg_config][0] = 1'b0;   // timing write stops the pulse
    endtask

    task automatic read_check(input logic [addr_width-1:0] addr, input logic [data_width-1:0] expected);
        send_cmd(1'b0, addr, '0);
        while (!rsp_valid) @(negedge clk);
        check_value("rsp_data", expected, rsp_data);
        @(negedge clk);   // taken on this edge, rsp_ready high
    endtask

    task automatic measure_pulse(input int p, input int t);
        int run;
        if (t == 0 || t >= p) begin
            repeat (3 * p) begin
                check_value("pwm_out", 32'(t != 0), 32'(pwm_out));
                @(negedge clk);
            end
        end else begin
            while (pwm_out) @(negedge clk);
            while (!pwm_out) @(negedge clk);   // line up on a rising edge
            repeat (2) begin
                for (run = 0; pwm_out; run++) @(negedge clk);
                check_value("pwm_out high run", t, run);
                for (run = 0; !pwm_out; run++) @(negedge clk);
                check_value("pwm_out low run", p - t, run);
            end
        end
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark && DUT.u_props.assert_fails == asrt_mark) begin
            passed++;
            $display("test %s: passed", name);
        end else begin
            failed++;
            $display("test %s: failed", name);
        end
        err_mark  = errors;
        asrt_mark = DUT.u_props.assert_fails;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        reset     = 1'b0;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_addr  = '0;
        cmd_data  = '0;
        rsp_ready = 1'b1;
        model     = '{default: '0};
        repeat (5) @(negedge clk);
        reset = 1'b1;

        // 1: random values, read back, enable cleared by timing writes
        for (int i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            write_reg(2'(i), (i == 2) ? (rng | 32'd1) : ((rng & 32'h00ff_ffff) | 32'h0001_0000));
        end
        for (int a = 0; a < 3; a++)
            read_check(2'(a), model[a]);
        read_check(reg_status, {1'b1, 15'd0, model[reg_config][15:0]});   // long high phase
        rng = xorshift32(rng);
        write_reg(reg_period, (rng & 32'h00ff_ffff) | 32'h0001_0000);
        read_check(reg_config, model[reg_config]);
        write_reg(reg_config, model[reg_config] | 32'd1);
        write_reg(reg_on_time, rng >> 8);
        for (int a = 0; a < 3; a++)
            read_check(2'(a), model[a]);
        read_check(reg_status, {1'b0, 15'd0, model[reg_config][15:0]});
        end_test("1 register read-back");

        // 2: pulse run lengths
        for (int k = 0; k < 5; k++) begin
            write_reg(reg_period, per_list[k]);
            write_reg(reg_on_time, on_list[k]);
            write_reg(reg_config, 32'h1);
            read_check(reg_config, 32'h1);   // config has landed, counters live
            measure_pulse(per_list[k], on_list[k]);
        end
        end_test("2 pulse lengths");

        // 3: every bridge field combination, pulse kept running
        write_reg(reg_period, 32'd4);
        write_reg(reg_on_time, 32'd2);
        for (int idx = 0; idx < 64; idx++) begin
            write_reg(reg_config, 32'((idx << 1) | 1));   // bits 6:1 walk all fields
            read_check(reg_config, model[reg_config]);
            repeat (4) begin
                check_value("h_bridge_2 h_bridge_1", bridge_pins(pwm_out, model[reg_config]),
                            {h_bridge_2, h_bridge_1});
                @(negedge clk);
            end
        end
        end_test("3 bridge decode");

        // 4: stalled responses fill the queue, then drain in order
        write_reg(reg_period, 32'h1234);
        write_reg(reg_on_time, 32'h0567);
        write_reg(reg_config, 32'h00ab_cd00);
        read_check(reg_config, model[reg_config]);   // pipeline empty
        rsp_ready = 1'b0;
        for (int i = 0; i < 6; i++)
            expect_q[i] = model[i % 3];
        for (int i = 0; i < 5; i++)
            send_cmd(1'b0, 2'(i % 3), '0);
        cmd_valid = 1'b1;   // sixth read, no credit left
        cmd_write = 1'b0;
        cmd_addr  = 2'd2;
        check_value("cmd_ready", 0, cmd_ready);
        while (!rsp_valid) @(negedge clk);
        held = rsp_data;
        repeat (4) begin
            @(negedge clk);
            check_value("rsp_valid", 1, rsp_valid);
            check_value("rsp_data", held, rsp_data);
        end
        rsp_ready = 1'b1;
        fork
            begin
                while (!cmd_ready) @(negedge clk);
                @(negedge clk);
                cmd_valid = 1'b0;
            end
            begin
                n = 0;
                while (n < 6) begin
                    if (rsp_valid) begin
                        check_value("rsp_data", expect_q[n], rsp_data);
                        n++;
                    end
                    @(negedge clk);
                end
            end
        join
        end_test("4 response back-pressure");

        // 5: reset while running with a response pending
        write_reg(reg_period, 32'd8);
        write_reg(reg_on_time, 32'd3);
        write_reg(reg_config, 32'h0000_000f);   // enable, bridge on, brake
        read_check(reg_config, model[reg_config]);
        rsp_ready = 1'b0;
        send_cmd(1'b0, reg_status, '0);
        while (!rsp_valid) @(negedge clk);
        reset = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value("cmd_ready rsp_valid pwm_out h_bridge_1 h_bridge_2", 0,
                        {cmd_ready, rsp_valid, pwm_out, h_bridge_1, h_bridge_2});
        end
        reset     = 1'b1;
        rsp_ready = 1'b1;
        model     = '{default: '0};
        for (int a = 0; a < 4; a++)
            read_check(2'(a), '0);
        end_test("5 reset mid-run");

        $display("summary: %0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/pwm_properties.sv */
/*
 * concurrent checks bound into pwm_subsystem
 * the pulse run check only applies while enable stays set
 * assert_fails is read hierarchically by the testbench
 */
`timescale 1ns/1ns
`default_nettype none

module pwm_properties (
    input logic                           clk, reset, cmd_ready,
    input logic                           rsp_valid, rsp_ready, pwm_out,
    input logic                           h_bridge_1, h_bridge_2,
    input logic [pwm_pkg::data_width-1:0] rsp_data, on_time,
    input pwm_pkg::pwm_cfg_t              cfg,
    input logic                           q_valid, q_credit,
    input logic                           c_valid, c_credit
);
    import pwm_pkg::*;

    int                      assert_fails = 0;
    logic [data_width-1:0]   high_run;     // rising edges seen with pwm high
    logic [credit_width-1:0] q_out;        // sent into the queue, credit not yet back
    logic [credit_width-1:0] c_out;        // sent into the channel, credit not yet back

    // pins as {pin 2, pin 1}
    function automatic logic [1:0] expected_pins(input logic p, input pwm_cfg_t c);
        logic [1:0] pins;
        pins = (c.f.bridge_cmd == br_brake)   ? 2'b11 :
               (c.f.bridge_cmd == br_forward) ? {1'b0, p} :
               (c.f.bridge_cmd == br_reverse) ? {p, 1'b0} : 2'b00;
        pins = c.f.swap ? {pins[0], pins[1]} : pins;
        return c.f.bridge_en ? (pins ^ c.f.invert) : 2'b00;
    endfunction

    task automatic note_failure(input string what);
        assert_fails++;
        $error("%s", what);
    endtask

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            high_run <= '0;
        else
            high_run <= pwm_out ? high_run + 1'b1 : '0;   // restarts on every low cycle
    end

    // outstanding commands per hop, counted from strobes and credit pulses only
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            q_out <= '0;
            c_out <= '0;
        end else begin
            case ({q_valid, q_credit})
                2'b10:   q_out <= q_out + 1'b1;
                2'b01:   q_out <= q_out - 1'b1;
                default: ;
            endcase
            case ({c_valid, c_credit})
                2'b10:   c_out <= c_out + 1'b1;
                2'b01:   c_out <= c_out - 1'b1;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // credit hops, response port, drive outputs

    a_queue_credit: assert property (@(posedge clk) disable iff (!reset)
        q_valid |-> q_out < queue_depth) else note_failure("queue strobe without credit");
    a_chan_credit: assert property (@(posedge clk) disable iff (!reset)
        c_valid |-> c_out < chan_slots) else note_failure("channel strobe without credit");
    a_rsp_hold: assert property (@(posedge clk) disable iff (!reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
        else note_failure("response changed while stalled");
    a_bridge: assert property (@(posedge clk) disable iff (!reset)
        {h_bridge_2, h_bridge_1} == expected_pins(pwm_out, cfg))
        else note_failure("bridge pins break the bridge rule");
    a_pulse: assert property (@(posedge clk) disable iff (!reset)
        $fell(pwm_out) && cfg.f.enable |-> high_run == on_time)
        else note_failure("pwm high run differs from on_time");
    a_reset_ready: assert property (@(posedge clk) !reset |-> !cmd_ready)
        else note_failure("cmd_ready high during reset");

endmodule

bind pwm_subsystem pwm_properties u_props (
    .*,
    .on_time  (u_channel.on_time),
    .q_valid  (q_in_if.valid),
    .q_credit (q_in_if.credit),
    .c_valid  (ch_in_if.valid),
    .c_credit (ch_in_if.credit)
);

`default_nettype wire

/* hw/pwm_subsystem.sv */
/*
 * top level: host target -> command queue -> pwm channel -> bridge decode
 * commands complete in order, read latency varies with queue fill
 */
`timescale 1ns/1ns
`default_nettype none

module pwm_subsystem (
    input  logic                           clk,
    input  logic                           reset,
    // host command port
    input  logic                           cmd_valid,
    input  logic                           cmd_write,
    input  logic [pwm_pkg::addr_width-1:0] cmd_addr,
    input  logic [pwm_pkg::data_width-1:0] cmd_data,
    output logic                           cmd_ready,
    // read response port
    input  logic                           rsp_ready,
    output logic                           rsp_valid,
    output logic [pwm_pkg::data_width-1:0] rsp_data,
    // drive outputs
    output logic                           pwm_out,
    output logic                           h_bridge_1,
    output logic                           h_bridge_2
);
    import pwm_pkg::*;

    pwm_cmd_if q_in_if ();    // target to queue
    pwm_cmd_if ch_in_if ();   // queue to channel

    pwm_cfg_t cfg;            // channel config, fields go to the decoder

    host_cmd_target u_target (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .cmd_ready (cmd_ready),
        .down      (q_in_if)
    );

    cmd_queue u_queue (
        .clk   (clk),
        .reset (reset),
        .up    (q_in_if),
        .down  (ch_in_if)
    );

    pwm_channel u_channel (
        .clk       (clk),
        .reset     (reset),
        .cmd       (ch_in_if),
        .rsp_ready (rsp_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .pwm       (pwm_out),
        .cfg       (cfg)
    );

    h_bridge_decode u_bridge (
        .pwm        (pwm_out),
        .cfg        (cfg),
        .h_bridge_1 (h_bridge_1),
        .h_bridge_2 (h_bridge_2)
    );

endmodule

`default_nettype wire

/* hw/h_bridge_decode.sv */
/*
 * combinational h-bridge pin decode from pwm and config fields
 * order is command, then swap, then invert, bridge enable overrides all
 */
`timescale 1ns/1ns
`default_nettype none

module h_bridge_decode (
    input  logic              pwm,
    input  pwm_pkg::pwm_cfg_t cfg,
    output logic              h_bridge_1,
    output logic              h_bridge_2
);
    import pwm_pkg::*;

    logic cmd_1, cmd_2;     // after command stage
    logic swp_1, swp_2;     // after swap stage

    always_comb begin
        // command stage
        case (cfg.f.bridge_cmd)
            br_coast:   begin cmd_1 = 1'b0; cmd_2 = 1'b0; end
            br_forward: begin cmd_1 = pwm;  cmd_2 = 1'b0; end
            br_reverse: begin cmd_1 = 1'b0; cmd_2 = pwm;  end
            br_brake:   begin cmd_1 = 1'b1; cmd_2 = 1'b1; end
            default:    begin cmd_1 = 1'b0; cmd_2 = 1'b0; end
        endcase

        // swap stage, for motors wired the other way round
        swp_1 = cfg.f.swap ? cmd_2 : cmd_1;
        swp_2 = cfg.f.swap ? cmd_1 : cmd_2;

        // invert stage, then the enable
        if (cfg.f.bridge_en) begin
            h_bridge_1 = swp_1 ^ cfg.f.invert[0];
            h_bridge_2 = swp_2 ^ cfg.f.invert[1];
        end else begin
            h_bridge_1 = 1'b0;   // bridge off, both pins low
            h_bridge_2 = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/pwm_channel.sv */
/*
 * pwm channel: period, on-time and config registers plus pulse counters
 * one command slot, writes retire next cycle, reads on response accept
 * a period or on-time write clears enable, status is read only
 */
`timescale 1ns/1ns
`default_nettype none

module pwm_channel (
    input  logic                           clk,
    input  logic                           reset,
    pwm_cmd_if.receiver                    cmd,
    input  logic                           rsp_ready,
    output logic                           rsp_valid,
    output logic [pwm_pkg::data_width-1:0] rsp_data,
    output logic                           pwm,
    output pwm_pkg::pwm_cfg_t              cfg
);
    import pwm_pkg::*;

    ////////////////////////////////////////////////////////////
    // registers and locals

    logic [data_width-1:0] period;     // cycles per period
    logic [data_width-1:0] on_time;    // high cycles per period

    logic [data_width-1:0] per_cnt;    // cycles left in this period
    logic [data_width-1:0] on_cnt;     // high cycles left
    logic                  running;    // counters loaded and live

    logic                  wr_arrive;  // write command this cycle
    logic                  rd_arrive;  // read command this cycle
    logic                  timing_wr;  // period or on-time written
    logic                  wr_done;    // write retired, credit due
    logic                  per_last;   // last cycle of the period
    logic                  on_zero;    // high phase over
    logic                  reload_times;
    logic                  dec_period;
    logic                  dec_on;
    logic [data_width-1:0] status_word;
    logic [data_width-1:0] rd_word;

    assign wr_arrive = cmd.valid && cmd.write;
    assign rd_arrive = cmd.valid && !cmd.write;
    assign timing_wr = wr_arrive &&
                       ((cmd.addr == reg_period) || (cmd.addr == reg_on_time));

    ////////////////////////////////////////////////////////////
    // register writes

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            period  <= '0;
            on_time <= '0;
            cfg.raw <= '0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= wr_arrive;
            if (wr_arrive) begin
                case (cmd.addr)
                    reg_period: begin
                        period       <= cmd.data;
                        cfg.f.enable <= 1'b0;   // stop so the next pulse starts clean
                    end
                    reg_on_time: begin
                        on_time      <= cmd.data;
                        cfg.f.enable <= 1'b0;
                    end
                    reg_config: cfg.raw <= cmd.data;   // whole word, rsvd kept
                    default: ;                          // status ignores writes
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // pulse counters, reload then count both down

    assign per_last     = (per_cnt <= 1);      // period 0 acts like period 1
    assign on_zero      = (on_cnt == '0);
    assign reload_times = !running || per_last;
    assign dec_period   = running && !per_last;
    assign dec_on       = dec_period && !on_zero;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            running <= 1'b0;
            per_cnt <= '0;
            on_cnt  <= '0;
        end else if (!cfg.f.enable || timing_wr) begin
            running <= 1'b0;   // idle, reload on next enable
            on_cnt  <= '0;
        end else if (reload_times) begin
            running <= 1'b1;
            per_cnt <= period;
            on_cnt  <= on_time;   // on_time >= period never reaches zero
        end else begin
            if (dec_period)
                per_cnt <= per_cnt - 1'b1;
            if (dec_on)
                on_cnt <= on_cnt - 1'b1;
        end
    end

    assign pwm = running && !on_zero;   // high while on-time remains

    ////////////////////////////////////////////////////////////
    // reads and response

    assign status_word = {pwm, {(data_width-17){1'b0}}, cfg.raw[15:0]};

    always_comb begin
        case (cmd.addr)
            reg_period:  rd_word = period;
            reg_on_time: rd_word = on_time;
            reg_config:  rd_word = cfg.raw;
            default:     rd_word = status_word;   // reg_status
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rsp_valid <= 1'b0;
        end else if (rd_arrive) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;   // accepted, or nothing pending
        end
    end

    always_ff @(posedge clk) begin
        if (rd_arrive)
            rsp_data <= rd_word;   // held until accepted, slot blocks new reads
    end

    // slot free again, write next cycle or read on accept
    assign cmd.credit = wr_done || (rsp_valid && rsp_ready);

endmodule

`default_nettype wire

/* hw/cmd_queue.sv */
/*
 * circular command buffer of queue_depth entries
 * trusts the sender to respect its credits, no overflow check
 * an entry leaves at the earliest one cycle after it arrives
 */
`timescale 1ns/1ns
`default_nettype none

module cmd_queue (
    input  logic        clk,
    input  logic        reset,
    pwm_cmd_if.receiver up,
    pwm_cmd_if.sender   down
);
    import pwm_pkg::*;

    // entry storage, no reset on the array
    logic                  mem_write [queue_depth];
    logic [addr_width-1:0] mem_addr  [queue_depth];
    logic [data_width-1:0] mem_data  [queue_depth];

    logic [ptr_width-1:0]    wr_ptr;
    logic [ptr_width-1:0]    rd_ptr;
    logic [credit_width-1:0] count;       // entries held
    logic [credit_width-1:0] dn_credits;  // free slots in the channel
    logic                    issue;       // entry leaves this cycle

    assign issue = (count != '0) && (dn_credits != '0);

    ////////////////////////////////////////////////////////////
    // write side

    always_ff @(posedge clk) begin
        if (up.valid) begin
            mem_write[wr_ptr] <= up.write;
            mem_addr[wr_ptr]  <= up.addr;
            mem_data[wr_ptr]  <= up.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers, occupancy, credits

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            dn_credits <= credit_width'(chan_slots);
            down.valid <= 1'b0;
            up.credit  <= 1'b0;
        end else begin
            if (up.valid)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at queue_depth
            if (issue)
                rd_ptr <= rd_ptr + 1'b1;

            if (up.valid && !issue)
                count <= count + 1'b1;
            else if (!up.valid && issue)
                count <= count - 1'b1;

            if (issue && !down.credit)
                dn_credits <= dn_credits - 1'b1;
            else if (!issue && down.credit)
                dn_credits <= dn_credits + 1'b1;

            down.valid <= issue;   // strobe toward the channel
            up.credit  <= issue;   // slot freed, tell the target
        end
    end

    // head entry onto the outgoing hop
    always_ff @(posedge clk) begin
        if (issue) begin
            down.write <= mem_write[rd_ptr];
            down.addr  <= mem_addr[rd_ptr];
            down.data  <= mem_data[rd_ptr];
        end
    end

endmodule

`default_nettype wire

/* hw/host_cmd_target.sv */
/*
 * host facing command target, valid/ready in and credit based out
 * cmd_ready stays low until credits load, one cycle after reset
 * a command reaches the interface one cycle after acceptance
 */
`timescale 1ns/1ns
`default_nettype none

module host_cmd_target (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cmd_valid,
    input  logic                           cmd_write,
    input  logic [pwm_pkg::addr_width-1:0] cmd_addr,
    input  logic [pwm_pkg::data_width-1:0] cmd_data,
    output logic                           cmd_ready,
    pwm_cmd_if.sender                      down
);
    import pwm_pkg::*;

    logic [credit_width-1:0] credits;   // free queue slots
    logic                    loaded;    // initial credit load done
    logic                    accept;    // host transfer this cycle

    ////////////////////////////////////////////////////////////
    // credit counter

    assign cmd_ready = (credits != '0);   // zero in reset, so ready is low
    assign accept    = cmd_valid && cmd_ready;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            credits <= '0;
            loaded  <= 1'b0;
        end else if (!loaded) begin
            // first cycle out of reset, the queue is empty
            credits <= credit_width'(queue_depth);
            loaded  <= 1'b1;
        end else if (accept && !down.credit) begin
            credits <= credits - 1'b1;   // slot spent
        end else if (!accept && down.credit) begin
            credits <= credits + 1'b1;   // slot back
        end
        // accept and credit together leave the count as it is
    end

    ////////////////////////////////////////////////////////////
    // command register toward the queue

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            down.valid <= 1'b0;
        end else begin
            down.valid <= accept;   // one cycle strobe per accepted command
        end
    end

    // payload only moves on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            down.write <= cmd_write;
            down.addr  <= cmd_addr;
            down.data  <= cmd_data;
        end
    end

endmodule

`default_nettype wire

/* hw/pwm_cmd_if.sv */
/*
 * one register command hop with a credit return path
 * valid is a single cycle strobe, credit a single cycle pulse
 */
`timescale 1ns/1ns
`default_nettype none

interface pwm_cmd_if;
    import pwm_pkg::*;

    logic                  valid;   // command strobe, one cycle per command
    logic                  write;   // 1 write, 0 read
    logic [addr_width-1:0] addr;    // register select
    logic [data_width-1:0] data;    // write data, ignored on reads
    logic                  credit;  // one slot freed downstream

    // upstream side, spends credits
    modport sender (
        output valid, write, addr, data,
        input  credit
    );

    // downstream side, returns credits
    modport receiver (
        input  valid, write, addr, data,
        output credit
    );

endinterface

`default_nettype wire

/* hw/pwm_pkg.sv */
/*
 * shared constants and the configuration word for the pwm channel
 * single channel only, register addresses 0..3
 * queue_depth must be a power of two, pointers wrap naturally
 */
`default_nettype none

package pwm_pkg;

    ////////////////////////////////////////////////////////////
    // widths and register map
    localparam int data_width   = 32;
    localparam int addr_width   = 2;

    localparam logic [addr_width-1:0] reg_period  = 2'd0;  // cycles per period
    localparam logic [addr_width-1:0] reg_on_time = 2'd1;  // high cycles per period
    localparam logic [addr_width-1:0] reg_config  = 2'd2;  // see pwm_cfg_fields_t
    localparam logic [addr_width-1:0] reg_status  = 2'd3;  // read only

    ////////////////////////////////////////////////////////////
    // flow control
    localparam int queue_depth  = 4;    // command slots, also host side credits
    localparam int ptr_width    = 2;    // log2 of queue_depth
    localparam int credit_width = 3;    // holds 0..queue_depth
    localparam int chan_slots   = 1;    // channel takes one command at a time

    // bridge commands
    localparam logic [1:0] br_coast   = 2'd0;
    localparam logic [1:0] br_forward = 2'd1;
    localparam logic [1:0] br_reverse = 2'd2;
    localparam logic [1:0] br_brake   = 2'd3;

    ////////////////////////////////////////////////////////////
    // configuration register, seen as fields or as a raw word
    typedef struct packed {
        logic [24:0] rsvd;          // stored as written, no function
        logic [1:0]  invert;        // bit 5 pin 1, bit 6 pin 2
        logic        swap;          // exchange the pins
        logic [1:0]  bridge_cmd;    // coast / forward / reverse / brake
        logic        bridge_en;     // pins held low when clear
        logic        enable;        // pulse generation on
    } pwm_cfg_fields_t;

    typedef union packed {
        logic [data_width-1:0] raw;  // host view
        pwm_cfg_fields_t       f;    // decode view
    } pwm_cfg_t;

endpackage

`default_nettype wire
